// ==== source/hazard_ctrl_pkg.sv ====
// Shared widths, vector types and stage bundles for the stall and flush controller
`default_nettype none

package hazard_ctrl_pkg;

    localparam int reg_idx_w    = 5;          // register file index
    localparam int addr_w       = 32;         // data address
    localparam int word_lsb     = 2;          // lowest bit of the word address
    localparam int ctrl_latency = 2;          // sampled inputs to registered outputs

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [addr_w-1:0]    addr_t;

    // source operands of the instruction sitting in ID
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
    } id_srcs_t;

    typedef struct packed {
        reg_idx_t dst;                         // destination written by the EXE instr
        logic     is_load;
    } exe_info_t;

    typedef struct packed {
        reg_idx_t rt;                          // load target in MEM
        logic     is_load;
        logic     is_store;
        addr_t    addr;
        logic     cached;                      // cacheable access
    } mem_info_t;

    // store that has left MEM but is not yet committed to the data cache
    typedef struct packed {
        logic     store_req;
        addr_t    addr;
        logic     cached;
    } store_slot_t;

    typedef struct packed {
        logic exception;                       // flush from the MEM exception check
        logic icache_busy;
        logic dcache_busy;
        logic mult_div_busy;
        logic branch_failed;                   // branch resolved against prediction
        logic imme_jump;                       // j / jal decoded in ID
    } side_causes_t;

    typedef struct packed {
        logic pc;
        logic if_s;
        logic id;
        logic exe;
        logic mem;
        logic mem2;
        logic wb;
    } stage_wr_t;

    typedef struct packed {
        logic if_s;
        logic id;
        logic exe;
        logic mem;
        logic mem2;
        logic wb;
    } stage_flush_t;

endpackage

`default_nettype wire

// ==== source/load_use_detect.sv ====
// Flags a load in EXE or MEM1 whose result the ID instruction reads, one cycle later
`timescale 1ns/1ps
`default_nettype none

module load_use_detect (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  hazard_ctrl_pkg::id_srcs_t   id_srcs,
    input  hazard_ctrl_pkg::exe_info_t  exe_info,
    input  hazard_ctrl_pkg::mem_info_t  mem_info,
    output logic                        ex_stall,
    output logic                        mem1_stall
);

    logic ex_hit;                              // combinational EXE hazard
    logic mem1_hit;                            // combinational MEM1 hazard

    // a load to r0 never produces a value, so it cannot block ID
    function automatic logic load_hits(
        input logic                      is_load,
        input hazard_ctrl_pkg::reg_idx_t dst,
        input hazard_ctrl_pkg::id_srcs_t srcs
    );
        logic dst_live;
        logic src_match;
        dst_live  = (dst != hazard_ctrl_pkg::reg_idx_t'(0));
        src_match = (dst == srcs.rs) || (dst == srcs.rt);
        return is_load && dst_live && src_match;
    endfunction

    always_comb begin
        ex_hit   = load_hits(exe_info.is_load, exe_info.dst, id_srcs);
        mem1_hit = load_hits(mem_info.is_load, mem_info.rt, id_srcs);
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            ex_stall   <= 1'b0;
            mem1_stall <= 1'b0;
        end else begin
            ex_stall   <= ex_hit;
            mem1_stall <= mem1_hit;
        end
    end

endmodule

`default_nettype wire

// ==== source/store_conflict_detect.sv ====
// Flags a MEM load that reads a word still owned by a pending MEM2 or WB store
`timescale 1ns/1ps
`default_nettype none

module store_conflict_detect (
    input  logic                         aclk,
    input  logic                         rst_n,
    input  hazard_ctrl_pkg::mem_info_t   mem_info,
    input  hazard_ctrl_pkg::store_slot_t mem2_store,
    input  hazard_ctrl_pkg::store_slot_t wb_store,
    output logic                         store_conflict
);

    logic mem2_hit;                            // load overlaps the MEM2 store
    logic wb_hit;                              // load overlaps the WB store
    logic conflict_d;

    // word granularity compare; byte lanes inside a word are not resolved
    function automatic logic slot_hits(
        input hazard_ctrl_pkg::store_slot_t slot,
        input hazard_ctrl_pkg::addr_t       addr,
        input logic                         cached
    );
        logic word_eq;
        logic path_eq;
        word_eq = (slot.addr[hazard_ctrl_pkg::addr_w-1:hazard_ctrl_pkg::word_lsb]
                   == addr[hazard_ctrl_pkg::addr_w-1:hazard_ctrl_pkg::word_lsb]);
        path_eq = (slot.cached == cached);     // cached and uncached go separate ways
        return slot.store_req && word_eq && path_eq;
    endfunction

    always_comb begin
        mem2_hit   = slot_hits(mem2_store, mem_info.addr, mem_info.cached);
        wb_hit     = slot_hits(wb_store, mem_info.addr, mem_info.cached);
        conflict_d = mem_info.is_load && (mem2_hit || wb_hit);
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            store_conflict <= 1'b0;
        end else begin
            store_conflict <= conflict_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/stage_control.sv ====
// Merges detector flags with sideband causes into per-stage write enables and flushes
`timescale 1ns/1ps
`default_nettype none

module stage_control (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  hazard_ctrl_pkg::side_causes_t  side_causes,
    input  logic                           ex_stall,
    input  logic                           mem1_stall,
    input  logic                           store_conflict,
    output hazard_ctrl_pkg::stage_wr_t     stage_wr,
    output hazard_ctrl_pkg::stage_flush_t  stage_flush
);

    hazard_ctrl_pkg::side_causes_t         side_q;      // aligned with the detector flags
    hazard_ctrl_pkg::stage_wr_t            wr_d;
    hazard_ctrl_pkg::stage_wr_t            wr_q;
    hazard_ctrl_pkg::stage_flush_t         flush_d;
    hazard_ctrl_pkg::stage_flush_t         flush_q;
    logic [hazard_ctrl_pkg::ctrl_latency-1:0] warm;     // one bit per register layer
    logic                                  out_valid;

    // first layer, sideband causes wait for the detectors
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            side_q <= '0;
        end else begin
            side_q <= side_causes;
        end
    end

    // fixed priority, first matching cause wins
    always_comb begin
        wr_d    = '1;                          // default is free running
        flush_d = '0;
        if (side_q.exception) begin
            flush_d.if_s = 1'b1;
            flush_d.id   = 1'b1;
            flush_d.exe  = 1'b1;
            flush_d.mem  = 1'b1;
            flush_d.mem2 = 1'b1;
        end else if (side_q.icache_busy || side_q.dcache_busy) begin
            wr_d = '0;                         // whole pipe frozen
        end else if (side_q.mult_div_busy) begin
            wr_d.pc     = 1'b0;
            wr_d.if_s   = 1'b0;
            wr_d.id     = 1'b0;
            wr_d.exe    = 1'b0;
            flush_d.mem = 1'b1;                // bubble behind the divider
        end else if (store_conflict) begin
            wr_d.pc      = 1'b0;
            wr_d.if_s    = 1'b0;
            wr_d.id      = 1'b0;
            wr_d.exe     = 1'b0;
            wr_d.mem     = 1'b0;
            flush_d.mem2 = 1'b1;               // load retries once the store drains
        end else if (ex_stall || mem1_stall) begin
            wr_d.pc     = 1'b0;
            wr_d.if_s   = 1'b0;
            wr_d.id     = 1'b0;
            flush_d.exe = 1'b1;
        end else if (side_q.branch_failed) begin
            flush_d.if_s = 1'b1;
            flush_d.id   = 1'b1;
        end else if (side_q.imme_jump) begin
            flush_d.if_s = 1'b1;               // delay slot in ID survives
        end
    end

    // second layer, registered stage controls
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_q    <= '0;
            flush_q <= '0;
        end else begin
            wr_q    <= wr_d;
            flush_q <= flush_d;
        end
    end

    // ones walk in behind reset, one stage per register layer
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            warm <= '0;
        end else begin
            warm <= {warm[hazard_ctrl_pkg::ctrl_latency-2:0], 1'b1};
        end
    end

    assign out_valid   = warm[hazard_ctrl_pkg::ctrl_latency-1];
    assign stage_wr    = out_valid ? wr_q : '0;    // zero until both layers hold real data
    assign stage_flush = out_valid ? flush_q : '0;

endmodule

`default_nettype wire

// ==== source/hazard_ctrl_top.sv ====
// Top of the stall and flush controller, drop-in for the CPU pipeline control block
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl_top (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  hazard_ctrl_pkg::id_srcs_t      id_srcs,
    input  hazard_ctrl_pkg::exe_info_t     exe_info,
    input  hazard_ctrl_pkg::mem_info_t     mem_info,
    input  hazard_ctrl_pkg::store_slot_t   mem2_store,
    input  hazard_ctrl_pkg::store_slot_t   wb_store,
    input  hazard_ctrl_pkg::side_causes_t  side_causes,
    output hazard_ctrl_pkg::stage_wr_t     stage_wr,
    output hazard_ctrl_pkg::stage_flush_t  stage_flush
);

    logic ex_stall;                            // load in EXE feeds ID
    logic mem1_stall;                          // load in MEM1 feeds ID
    logic store_conflict;                      // MEM load behind a pending store

    load_use_detect u_load_use_detect (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .id_srcs        (id_srcs),
        .exe_info       (exe_info),
        .mem_info       (mem_info),
        .ex_stall       (ex_stall),
        .mem1_stall     (mem1_stall)
    );

    store_conflict_detect u_store_conflict_detect (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .mem_info       (mem_info),
        .mem2_store     (mem2_store),
        .wb_store       (wb_store),
        .store_conflict (store_conflict)
    );

    stage_control u_stage_control (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .side_causes    (side_causes),
        .ex_stall       (ex_stall),
        .mem1_stall     (mem1_stall),
        .store_conflict (store_conflict),
        .stage_wr       (stage_wr),
        .stage_flush    (stage_flush)
    );

endmodule

`default_nettype wire

// ==== verif/hazard_ctrl_tb.sv ====
// Replays the stim file into hazard_ctrl_top and checks the stage vectors two cycles later
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl_tb;

    localparam int    clk_period   = 40;
    localparam int    reset_cycles = 3;
    localparam int    margin       = 20;
    localparam int    field_count  = 19;
    localparam string stim_path    = "verif/hazard_ctrl_stim.txt";

    // one parsed line of the stim file
    typedef struct packed {
        logic [7:0]                    test_id;
        hazard_ctrl_pkg::id_srcs_t     id_srcs;
        hazard_ctrl_pkg::exe_info_t    exe_info;
        hazard_ctrl_pkg::mem_info_t    mem_info;
        hazard_ctrl_pkg::store_slot_t  mem2_store;
        hazard_ctrl_pkg::store_slot_t  wb_store;
        hazard_ctrl_pkg::side_causes_t side_causes;
        hazard_ctrl_pkg::stage_wr_t    exp_wr;
        hazard_ctrl_pkg::stage_flush_t exp_flush;
    } stim_line_t;

    typedef struct packed {
        logic [7:0]                    test_id;
        hazard_ctrl_pkg::stage_wr_t    wr;
        hazard_ctrl_pkg::stage_flush_t flush;
    } expect_t;

    logic                          aclk;
    logic                          rst_n;
    hazard_ctrl_pkg::id_srcs_t     id_srcs;
    hazard_ctrl_pkg::exe_info_t    exe_info;
    hazard_ctrl_pkg::mem_info_t    mem_info;
    hazard_ctrl_pkg::store_slot_t  mem2_store;
    hazard_ctrl_pkg::store_slot_t  wb_store;
    hazard_ctrl_pkg::side_causes_t side_causes;
    hazard_ctrl_pkg::stage_wr_t    stage_wr;
    hazard_ctrl_pkg::stage_flush_t stage_flush;

    stim_line_t stim_q [$];
    expect_t    pipe [2];                        // two-deep expectation delay line
    expect_t    pending;                         // line driven, not yet sampled
    logic [7:0] cur_test;
    int         test_errors;
    int         errors;
    int         tests_passed;
    int         tests_failed;
    int         cycle_count;
    int         cycle_limit;

    hazard_ctrl_top dut_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .id_srcs     (id_srcs),
        .exe_info    (exe_info),
        .mem_info    (mem_info),
        .mem2_store  (mem2_store),
        .wb_store    (wb_store),
        .side_causes (side_causes),
        .stage_wr    (stage_wr),
        .stage_flush (stage_flush)
    );

    always #(clk_period / 2) aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not reach its end", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic read_stim();
        int          fd;
        int          n;
        string       text;
        logic [31:0] f [field_count];
        stim_line_t  s;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("could not open the stim file %s", stim_path);
            errors++;
            return;
        end
        while ($fgets(text, fd) > 0) begin
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;                        // blank or column legend
            end
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
            if (n != field_count) begin
                $display("stim line has %0d fields instead of %0d: %s", n, field_count, text);
                errors++;
                continue;
            end
            s.test_id             = f[0][7:0];
            s.id_srcs.rs          = hazard_ctrl_pkg::reg_idx_t'(f[1]);
            s.id_srcs.rt          = hazard_ctrl_pkg::reg_idx_t'(f[2]);
            s.exe_info.dst        = hazard_ctrl_pkg::reg_idx_t'(f[3]);
            s.exe_info.is_load    = f[4][0];
            s.mem_info.rt         = hazard_ctrl_pkg::reg_idx_t'(f[5]);
            s.mem_info.is_load    = f[6][0];
            s.mem_info.is_store   = f[7][0];
            s.mem_info.addr       = f[8];
            s.mem_info.cached     = f[9][0];
            s.mem2_store.store_req = f[10][0];
            s.mem2_store.addr     = f[11];
            s.mem2_store.cached   = f[12][0];
            s.wb_store.store_req  = f[13][0];
            s.wb_store.addr       = f[14];
            s.wb_store.cached     = f[15][0];
            s.side_causes         = hazard_ctrl_pkg::side_causes_t'(f[16]);
            s.exp_wr              = hazard_ctrl_pkg::stage_wr_t'(f[17]);
            s.exp_flush           = hazard_ctrl_pkg::stage_flush_t'(f[18]);
            stim_q.push_back(s);
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            $display("the stim file holds no usable lines");
            errors++;
        end
    endtask

    task automatic apply_inputs(input stim_line_t s);
        id_srcs     <= s.id_srcs;
        exe_info    <= s.exe_info;
        mem_info    <= s.mem_info;
        mem2_store  <= s.mem2_store;
        wb_store    <= s.wb_store;
        side_causes <= s.side_causes;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("test %0h done, no errors", cur_test);
            tests_passed++;
        end else begin
            $display("test %0h done, %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic check_outputs(input expect_t e);
        if (e.test_id != cur_test) begin
            close_test();
            cur_test = e.test_id;
        end
        if (stage_wr !== e.wr) begin
            $display("Mismatch stage_wr: got %h expected %h (test %0h)",
                     stage_wr, e.wr, e.test_id);
            test_errors++;
        end
        if (stage_flush !== e.flush) begin
            $display("Mismatch stage_flush: got %h expected %h (test %0h)",
                     stage_flush, e.flush, e.test_id);
            test_errors++;
        end
    endtask

    // drive on the rising edge, compare on the falling edge
    task automatic run_cycle(input stim_line_t s, input expect_t next, input logic end_reset);
        @(posedge aclk);
        pipe[1] = pipe[0];
        pipe[0] = pending;                       // line sampled at this edge
        apply_inputs(s);
        if (end_reset) begin
            rst_n <= 1'b1;
        end
        pending = next;
        @(negedge aclk);
        check_outputs(pipe[1]);
    endtask

    initial begin
        stim_line_t idle;
        expect_t    reset_entry;
        expect_t    line_entry;
        expect_t    drain_entry;
        aclk         = 1'b0;
        rst_n        = 1'b0;
        id_srcs      = '0;
        exe_info     = '0;
        mem_info     = '0;
        mem2_store   = '0;
        wb_store     = '0;
        side_causes  = '0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        idle         = '0;
        drain_entry  = '0;

        read_stim();
        cycle_limit = stim_q.size() + reset_cycles + hazard_ctrl_pkg::ctrl_latency + margin;

        // reset and warm-up slots expect all zero and count toward the first test
        reset_entry = '0;
        if (stim_q.size() > 0) begin
            reset_entry.test_id = stim_q[0].test_id;
        end
        cur_test = reset_entry.test_id;
        pipe[0]  = reset_entry;
        pipe[1]  = reset_entry;
        pending  = reset_entry;

        repeat (reset_cycles - 1) begin
            run_cycle(idle, reset_entry, 1'b0);
        end
        foreach (stim_q[i]) begin
            line_entry.test_id = stim_q[i].test_id;
            line_entry.wr      = stim_q[i].exp_wr;
            line_entry.flush   = stim_q[i].exp_flush;
            run_cycle(stim_q[i], line_entry, i == 0);   // first line goes with reset release
        end
        repeat (hazard_ctrl_pkg::ctrl_latency) begin
            run_cycle(idle, drain_entry, 1'b0);
        end

        close_test();
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hazard_ctrl.f ====
source/hazard_ctrl_pkg.sv
source/load_use_detect.sv
source/store_conflict_detect.sv
source/stage_control.sv
source/hazard_ctrl_top.sv
verif/hazard_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: hazard_ctrl

sources:
  # package first, then the detectors, controller and top level
  - source/hazard_ctrl_pkg.sv
  - source/load_use_detect.sv
  - source/store_conflict_detect.sv
  - source/stage_control.sv
  - source/hazard_ctrl_top.sv
  - target: test
    files:
      - verif/hazard_ctrl_tb.sv

// ==== verif/hazard_ctrl_stim.txt ====
# id rs rt exe_dst exe_ld mem_rt mem_ld mem_st mem_addr mem_c m2_req m2_addr m2_c
# wb_req wb_addr wb_c side_causes exp_stage_wr exp_stage_flush, all fields in hex
1 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
1 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
1 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
2 05 03 05 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 0f 08
2 05 03 03 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 0f 08
2 07 09 00 0 09 1 0 00000000 0 0 00000000 0 0 00000000 0 00 0f 08
2 0a 01 00 0 0a 1 0 00000000 0 0 00000000 0 0 00000000 0 00 0f 08
2 00 04 00 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
2 00 00 00 0 00 1 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
2 05 00 05 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
2 06 00 00 0 06 0 1 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
2 01 02 03 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
2 1f 00 1f 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 0f 08
3 00 00 00 0 00 1 0 00001000 1 1 00001000 1 0 00000000 0 00 03 02
3 00 00 00 0 00 1 0 00001004 1 0 00000000 0 1 00001004 1 00 03 02
3 00 00 00 0 00 1 0 00001002 1 1 00001000 1 0 00000000 0 00 03 02
3 00 00 00 0 00 1 0 00001000 1 1 00001004 1 0 00000000 0 00 7f 00
3 00 00 00 0 00 1 0 00001000 1 1 00001000 0 0 00000000 0 00 7f 00
3 00 00 00 0 00 1 0 00001000 1 0 00001000 1 0 00000000 0 00 7f 00
3 00 00 00 0 00 0 1 00001000 1 1 00001000 1 1 00001000 1 00 7f 00
3 00 00 00 0 00 1 0 80001000 1 1 00001000 1 0 00000000 0 00 7f 00
3 00 00 00 0 00 1 0 1fc00010 0 0 00000000 0 1 1fc00010 0 00 03 02
4 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 10 00 00
4 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 08 00 00
4 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 18 00 00
4 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 04 07 04
4 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
5 05 00 05 1 00 1 0 00002000 1 1 00002000 1 0 00000000 0 3f 7f 3e
5 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 20 7f 3e
5 05 00 05 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 10 00 00
5 00 00 00 0 00 1 0 00002000 1 0 00000000 0 1 00002000 1 08 00 00
5 00 00 00 0 00 1 0 00002000 1 1 00002000 1 0 00000000 0 04 07 04
5 05 00 05 1 00 1 0 00002000 1 1 00002000 1 0 00000000 0 00 03 02
5 05 00 05 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 02 0f 08
5 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 02 7f 30
5 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 01 7f 20
5 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 03 7f 30
5 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 06 07 04
6 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 20 7f 3e
6 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 10 00 00
6 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 04 07 04
6 0c 00 0c 1 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 0f 08
6 00 00 00 0 00 1 0 00003000 0 0 00000000 0 1 00003000 0 00 03 02
6 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 02 7f 30
6 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 01 7f 20
6 00 00 00 0 00 0 0 00000000 0 0 00000000 0 0 00000000 0 00 7f 00
